// File: include/dcache_params.svh
/*
 * Geometry of the two-way data cache.
 * The widths must stay consistent: tag + index + offset + byte = address.
 * Changing DC_WAYS beyond 2 needs a wider LRU scheme than one bit per set.
 */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// line geometry
`define DC_SETS     256
`define DC_WAYS     2
`define DC_WORDS    4

// address split
`define DC_INDEX_W  8
`define DC_TAG_W    20
`define DC_OFFSET_W 2     // word within line
`define DC_BYTE_W   2     // byte within word, ignored

// bus widths
`define DC_ADDR_W   32
`define DC_WORD_W   32

`endif

// File: sources.f
+incdir+include
src/apb_pkg.sv
src/cache_pkg.sv
src/sync_ram.sv
src/dtag_ram.sv
src/data_ram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/tb_l2_model.sv
tb/tb_dcache.sv

// File: src/apb_pkg.sv
/*
 * CPU side APB types.
 * No pstrb and no pprot. Only full-word transfers are supported.
 * pslverr is part of the response but the cache never raises it.
 */
`include "dcache_params.svh"

package apb_pkg;

    // master to cache
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`DC_ADDR_W-1:0] paddr;
        logic [`DC_WORD_W-1:0] pwdata;
    } apb_req_t;

    // cache to master
    typedef struct packed {
        logic                  pready;
        logic [`DC_WORD_W-1:0] prdata;
        logic                  pslverr;   // tied low
    } apb_rsp_t;

endpackage

// File: src/cache_pkg.sv
/*
 * Cache internal types and the L2 port.
 * L2 reads move a whole line and return it in the ack cycle.
 * L2 writes carry a single word. One request outstanding at a time.
 */
`include "dcache_params.svh"

package cache_pkg;

    typedef logic [`DC_WORD_W-1:0]  dc_word_t;
    typedef logic [`DC_INDEX_W-1:0] dc_index_t;

    // how the cache sees a cpu address
    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        dc_index_t               index;
        logic [`DC_OFFSET_W-1:0] offset;
        logic [`DC_BYTE_W-1:0]   byte_sel;   // unused, word accesses only
    } dc_addr_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef dc_word_t [`DC_WORDS-1:0] dc_line_t;   // word 0 in the low bits

    // one enable per word bank, per way
    typedef logic [`DC_WAYS-1:0][`DC_WORDS-1:0] way_wen_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [`DC_ADDR_W-1:0] addr;    // line aligned on reads
        dc_word_t              wdata;
    } l2_req_t;

    typedef struct packed {
        logic     ack;
        dc_line_t rdata;
    } l2_rsp_t;

endpackage

// File: src/data_ram.sv
/*
 * Data store, two ways of four 32-bit word banks each.
 * One write line is shared by all banks. The store word is always laid
 * over it at offset, so on a plain refill the controller hands back the
 * refill word itself. Only the enabled banks take the write.
 */
`include "dcache_params.svh"

module data_ram (
    input  logic                                clk,
    input  cache_pkg::dc_index_t                index,
    input  cache_pkg::way_wen_t                 wen,
    input  logic [`DC_OFFSET_W-1:0]             offset,
    input  cache_pkg::dc_word_t                 store_word,
    input  cache_pkg::dc_line_t                 refill_line,
    input  logic                                refill_sel,
    output cache_pkg::dc_line_t [`DC_WAYS-1:0]  lines
);

    import cache_pkg::*;

    dc_line_t wr_line;
    logic     wr_way;

    // base line is either the L2 line or what the way holds now
    always_comb begin
        wr_way          = |wen[1];
        wr_line         = refill_sel ? refill_line : lines[wr_way];
        wr_line[offset] = store_word;     // merge of store and refill
    end

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        for (genvar b = 0; b < `DC_WORDS; b++) begin : g_bank
            sync_ram #(
                .entry_t (dc_word_t),
                .depth   (`DC_SETS)
            ) bank_i (
                .clk     (clk),
                .addr    (index),
                .wen     (wen[w][b]),
                .wdata   (wr_line[b]),
                .rdata   (lines[w][b])
            );
        end
    end

endmodule

// File: src/dcache_ctrl.sv
/*
 * Cache controller. Judges hit or miss, picks the way and sequences
 * refill and write-through on the L2 port.
 * Index is taken from paddr combinationally, so the arrays are read in
 * the APB setup cycle. Relies on the master holding its request stable.
 * A read hit completes in the first access cycle.
 */
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    input  apb_pkg::apb_req_t                   apb_req,
    output apb_pkg::apb_rsp_t                   apb_rsp,
    output cache_pkg::l2_req_t                  l2_req,
    input  cache_pkg::l2_rsp_t                  l2_rsp,
    output cache_pkg::dc_index_t                index,
    output logic [`DC_WAYS-1:0]                 tag_wen,
    output cache_pkg::tag_entry_t               tag_wdata,
    output logic                                lru_upd,
    output logic                                lru_way,
    input  cache_pkg::tag_entry_t [`DC_WAYS-1:0] tags,
    input  logic                                lru,
    output cache_pkg::way_wen_t                 data_wen,
    output logic [`DC_OFFSET_W-1:0]             offset,
    output cache_pkg::dc_word_t                 store_word,
    output cache_pkg::dc_line_t                 refill_line,
    output logic                                refill_sel,
    input  cache_pkg::dc_line_t [`DC_WAYS-1:0]  lines
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,     // first access cycle, array outputs valid
        S_REFILL,     // waiting for the L2 line
        S_REREAD,     // array re-reads the new line
        S_WTHRU,      // waiting for the L2 word write
        S_DONE
    } state_t;

    state_t              state_q;
    state_t              state_d;
    dc_addr_t            addr;
    logic [`DC_WAYS-1:0] way_hit;
    logic                hit;
    logic                hit_way;
    logic                cur_way;
    logic                way_q;       // way kept after lookup
    logic                line_rd_req;
    logic                word_wr_req;
    logic                refill_ack;
    logic                wthru_ack;

    assign addr        = dc_addr_t'(apb_req.paddr);
    assign index       = addr.index;
    assign offset      = addr.offset;
    assign refill_line = l2_rsp.rdata;
    assign tag_wdata   = '{valid: 1'b1, tag: addr.tag};

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_cmp
        assign way_hit[w] = tags[w].valid && (tags[w].tag == addr.tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    // hit way or LRU victim during lookup, the stored way afterwards
    assign cur_way = (state_q == S_LOOKUP) ? (hit ? hit_way : lru) : way_q;

    // L2 request is a pure function of state and the held APB request
    assign line_rd_req = (state_q == S_LOOKUP && !hit) || state_q == S_REFILL;
    assign word_wr_req = (state_q == S_LOOKUP && hit && apb_req.pwrite)
                         || state_q == S_WTHRU;
    assign refill_ack  = line_rd_req && l2_rsp.ack;
    assign wthru_ack   = word_wr_req && l2_rsp.ack;

    always_comb begin
        l2_req.valid = line_rd_req || word_wr_req;
        l2_req.we    = word_wr_req;
        l2_req.wdata = apb_req.pwdata;
        if (word_wr_req) begin
            l2_req.addr = {addr.tag, addr.index, addr.offset, {`DC_BYTE_W{1'b0}}};
        end else begin
            l2_req.addr = {addr.tag, addr.index, {(`DC_OFFSET_W + `DC_BYTE_W){1'b0}}};
        end
    end

    // a read refill gets its own word back, so the merge is a no-op
    assign store_word = apb_req.pwrite ? apb_req.pwdata : l2_rsp.rdata[offset];

    always_comb begin
        tag_wen    = '0;
        data_wen   = '0;
        lru_upd    = 1'b0;
        lru_way    = 1'b0;
        refill_sel = 1'b0;
        if (refill_ack) begin
            tag_wen[cur_way]  = 1'b1;
            data_wen[cur_way] = '1;          // whole line, store merged in
            refill_sel        = 1'b1;
            lru_upd           = 1'b1;
            lru_way           = ~cur_way;    // filled way is now most recent
        end else if (state_q == S_LOOKUP && hit) begin
            lru_upd = 1'b1;
            lru_way = ~hit_way;
            if (apb_req.pwrite) begin
                data_wen[hit_way][offset] = 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (apb_req.psel && !apb_req.penable) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (!hit) begin
                    if (refill_ack) begin
                        state_d = apb_req.pwrite ? S_WTHRU : S_REREAD;
                    end else begin
                        state_d = S_REFILL;
                    end
                end else if (apb_req.pwrite) begin
                    state_d = wthru_ack ? S_DONE : S_WTHRU;
                end else begin
                    state_d = S_IDLE;   // read hit done
                end
            end
            S_REFILL: begin
                if (refill_ack) begin
                    state_d = apb_req.pwrite ? S_WTHRU : S_REREAD;
                end
            end
            S_REREAD: state_d = S_DONE;
            S_WTHRU: begin
                if (wthru_ack) begin
                    state_d = S_DONE;
                end
            end
            S_DONE:   state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
            way_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_LOOKUP) begin
                way_q <= cur_way;
            end
        end
    end

    assign apb_rsp.pready  = (state_q == S_LOOKUP && hit && !apb_req.pwrite)
                             || state_q == S_DONE;
    assign apb_rsp.prdata  = lines[cur_way][offset];
    assign apb_rsp.pslverr = 1'b0;

endmodule

// File: src/dcache_top.sv
/*
 * Data cache top. APB slave toward the CPU, line port toward L2.
 * Two ways, write-through with write-allocate, one LRU bit per set.
 */
`include "dcache_params.svh"

module dcache_top (
    input  logic                clk,
    input  logic                arst_n,
    input  apb_pkg::apb_req_t   apb_req,
    output apb_pkg::apb_rsp_t   apb_rsp,
    output cache_pkg::l2_req_t  l2_req,
    input  cache_pkg::l2_rsp_t  l2_rsp
);

    import cache_pkg::*;

    dc_index_t                   index;
    logic [`DC_WAYS-1:0]         tag_wen;
    tag_entry_t                  tag_wdata;
    logic                        lru_upd;
    logic                        lru_way;
    tag_entry_t [`DC_WAYS-1:0]   tags;
    logic                        lru;
    way_wen_t                    data_wen;
    logic [`DC_OFFSET_W-1:0]     offset;
    dc_word_t                    store_word;
    dc_line_t                    refill_line;
    logic                        refill_sel;
    dc_line_t [`DC_WAYS-1:0]     lines;

    dtag_ram dtag_ram_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (index),
        .tag_wen     (tag_wen),
        .tag_wdata   (tag_wdata),
        .lru_upd     (lru_upd),
        .lru_way     (lru_way),
        .tags        (tags),
        .lru         (lru)
    );

    data_ram data_ram_i (
        .clk         (clk),
        .index       (index),
        .wen         (data_wen),
        .offset      (offset),
        .store_word  (store_word),
        .refill_line (refill_line),
        .refill_sel  (refill_sel),
        .lines       (lines)
    );

    dcache_ctrl dcache_ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .l2_req      (l2_req),
        .l2_rsp      (l2_rsp),
        .index       (index),
        .tag_wen     (tag_wen),
        .tag_wdata   (tag_wdata),
        .lru_upd     (lru_upd),
        .lru_way     (lru_way),
        .tags        (tags),
        .lru         (lru),
        .data_wen    (data_wen),
        .offset      (offset),
        .store_word  (store_word),
        .refill_line (refill_line),
        .refill_sel  (refill_sel),
        .lines       (lines)
    );

endmodule

// File: src/dtag_ram.sv
/*
 * Tag store for both ways plus the per-set LRU bits.
 * Valid and LRU bits live in flops so reset clears them, the tag RAM
 * itself comes up unknown. All outputs arrive one cycle after index.
 * lru names the way to replace next.
 */
`include "dcache_params.svh"

module dtag_ram (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  cache_pkg::dc_index_t                  index,
    input  logic [`DC_WAYS-1:0]                   tag_wen,
    input  cache_pkg::tag_entry_t                 tag_wdata,
    input  logic                                  lru_upd,
    input  logic                                  lru_way,
    output cache_pkg::tag_entry_t [`DC_WAYS-1:0]  tags,
    output logic                                  lru
);

    import cache_pkg::*;

    tag_entry_t [`DC_WAYS-1:0] ram_rd;    // raw RAM outputs
    logic       [`DC_SETS-1:0] lru_q;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic [`DC_SETS-1:0] valid_q;
        logic                valid_rd;

        sync_ram #(
            .entry_t (tag_entry_t),
            .depth   (`DC_SETS)
        ) tag_ram_i (
            .clk     (clk),
            .addr    (index),
            .wen     (tag_wen[w]),
            .wdata   (tag_wdata),
            .rdata   (ram_rd[w])
        );

        // valid flags, read-first like the RAM beside them
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q  <= '0;
                valid_rd <= 1'b0;
            end else begin
                if (tag_wen[w]) begin
                    valid_q[index] <= tag_wdata.valid;
                end
                valid_rd <= valid_q[index];
            end
        end

        // stored valid is unknown after reset, so mask it
        assign tags[w].valid = ram_rd[w].valid & valid_rd;
        assign tags[w].tag   = ram_rd[w].tag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;              // all sets replace way 0 first
            lru   <= 1'b0;
        end else begin
            if (lru_upd) begin
                lru_q[index] <= lru_way;
            end
            lru <= lru_q[index];      // lines up with the tag read
        end
    end

endmodule

// File: src/sync_ram.sv
/*
 * Single-port synchronous RAM, read-first.
 * rdata registers the addressed entry on every edge, so a write returns
 * the old contents in the next cycle. No reset on the array or on rdata.
 */
module sync_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 256
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     wen,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // old value on a write edge
    end

endmodule

// File: tb/tb_dcache.sv
/*
 * Testbench for the data cache. Drives APB on falling edges and checks
 * each transfer against a shadow of memory, tags and LRU bits.
 * Hit or miss is judged from the L2 line-read count of each transfer.
 * The run is bounded by a cycle limit of 200 transfers of 12 cycles.
 */
`include "dcache_params.svh"

module tb_dcache;

    import apb_pkg::*;
    import cache_pkg::*;

    localparam logic [31:0] fill_key   = 32'h5a5a_c3c3;   // same rule as L2 fill
    localparam int          max_cycles = 200 * 12;

    logic     clk;
    logic     arst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    l2_req_t  l2_req;
    l2_rsp_t  l2_rsp;
    int       line_reads;
    int       word_writes;

    logic [31:0]          shadow_mem [logic [29:0]];
    logic [`DC_TAG_W-1:0] shadow_tag [`DC_SETS][`DC_WAYS];
    logic                 shadow_valid [`DC_SETS][`DC_WAYS];
    logic                 shadow_lru [`DC_SETS];   // way to replace next

    // last finished transfer, handed to the compare process
    string       test_name;
    logic        res_write;
    logic        res_miss;
    logic        res_slverr;
    logic [31:0] res_addr;
    logic [31:0] res_exp;
    logic [31:0] res_act;
    int          res_lines;
    int          res_words;
    int          res_cycles;
    logic        res_valid;    // high while a result waits to be compared

    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          cycles;
    logic [31:0] rng;

    dcache_top dcache_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .l2_req  (l2_req),
        .l2_rsp  (l2_rsp)
    );

    tb_l2_model #(.seed(32'd19333)) l2_model_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .l2_req      (l2_req),
        .l2_rsp      (l2_rsp),
        .line_reads  (line_reads),
        .word_writes (word_writes)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] waddr);
        if (shadow_mem.exists(waddr)) begin
            return shadow_mem[waddr];
        end
        return {waddr, 2'b00} ^ fill_key;
    endfunction

    // reference model, updates the shadow state and predicts the access
    function automatic logic [31:0] predict(input logic wr, input logic [31:0] addr,
                                            input logic [31:0] wdata, output logic miss);
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] idx;
        int                     way;
        tag = addr[31:12];
        idx = addr[11:4];
        way = -1;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (shadow_valid[idx][w] && shadow_tag[idx][w] == tag) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            way = shadow_lru[idx];             // victim
            shadow_valid[idx][way] = 1'b1;
            shadow_tag[idx][way]   = tag;
        end
        shadow_lru[idx] = (way == 0);          // other way goes next
        if (wr) begin
            shadow_mem[addr[31:2]] = wdata;
        end
        return mem_word(addr[31:2]);
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] idx,
                                              input logic [1:0] off);
        return {tag, idx, off, 2'b00};
    endfunction

    // one APB transfer, entered and left on a falling edge
    task automatic run_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata);
        logic        exp_miss;
        logic [31:0] exp_data;
        int          lines0;
        int          words0;
        int          waited;
        exp_data        = predict(wr, addr, wdata, exp_miss);
        lines0          = line_reads;
        words0          = word_writes;
        apb_req.psel    = 1'b1;                // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waited          = 1;
        while (!apb_rsp.pready) begin
            @(negedge clk);
            waited++;
        end
        res_act    = apb_rsp.prdata;
        res_slverr = apb_rsp.pslverr;
        @(negedge clk);                        // transfer ended on the rising edge
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        res_write  = wr;
        res_addr   = addr;
        res_exp    = exp_data;
        res_miss   = exp_miss;
        res_lines  = line_reads - lines0;
        res_words  = word_writes - words0;
        res_cycles = waited;
        res_valid  = 1'b1;
        wait (!res_valid);                     // compare process has taken it
    endtask

    initial begin
        forever begin
            wait (res_valid);
            checks += 5;
            test_checks += 5;
            if (!res_write && res_act !== res_exp) begin
                $display("error %s: read %h expected %h actual %h",
                         test_name, res_addr, res_exp, res_act);
                errors++;
                test_errors++;
            end
            if (res_lines != int'(res_miss)) begin
                $display("error %s: line reads for %h expected %0d actual %0d",
                         test_name, res_addr, int'(res_miss), res_lines);
                errors++;
                test_errors++;
            end
            if (res_words != int'(res_write)) begin
                $display("error %s: word writes for %h expected %0d actual %0d",
                         test_name, res_addr, int'(res_write), res_words);
                errors++;
                test_errors++;
            end
            if (!res_write && !res_miss && res_cycles != 1) begin
                $display("error %s: read hit access cycles for %h expected 1 actual %0d",
                         test_name, res_addr, res_cycles);
                errors++;
                test_errors++;
            end
            if (res_slverr !== 1'b0) begin
                $display("error %s: pslverr for %h expected 0 actual %b",
                         test_name, res_addr, res_slverr);
                errors++;
                test_errors++;
            end
            res_valid = 1'b0;
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic check_idle_outputs();
        checks++;
        test_checks++;
        if (apb_rsp.pready !== 1'b0 || l2_req.valid !== 1'b0) begin
            $display("error %s: pready/l2 valid expected 0/0 actual %b/%b",
                     test_name, apb_rsp.pready, l2_req.valid);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        logic [31:0] r;
        apb_req   = '0;
        arst_n    = 1'b0;
        rng       = 32'd19333;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        res_valid = 1'b0;
        for (int s = 0; s < `DC_SETS; s++) begin
            shadow_lru[s] = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_tag[s][w]   = '0;
            end
        end

        start_test("reset_state");
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs();
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        run_transfer(1'b0, make_addr(20'h00010, 8'h00, 2'd0), '0);
        end_test();

        start_test("read_miss_hit");
        run_transfer(1'b0, make_addr(20'h00020, 8'h01, 2'd1), '0);
        run_transfer(1'b0, make_addr(20'h00020, 8'h01, 2'd3), '0);
        end_test();

        start_test("write_hit");
        run_transfer(1'b1, make_addr(20'h00020, 8'h01, 2'd2), 32'hcafe_0001);
        run_transfer(1'b0, make_addr(20'h00020, 8'h01, 2'd2), '0);
        end_test();

        start_test("write_miss");
        run_transfer(1'b1, make_addr(20'h00030, 8'h02, 2'd1), 32'hbeef_0002);
        for (int o = 0; o < 4; o++) begin
            run_transfer(1'b0, make_addr(20'h00030, 8'h02, 2'(o)), '0);
        end
        end_test();

        start_test("way_replace");
        run_transfer(1'b0, make_addr(20'h00041, 8'h03, 2'd0), '0);
        run_transfer(1'b0, make_addr(20'h00042, 8'h03, 2'd0), '0);
        run_transfer(1'b0, make_addr(20'h00042, 8'h03, 2'd1), '0);   // both tags resident
        run_transfer(1'b0, make_addr(20'h00041, 8'h03, 2'd1), '0);   // second tag is LRU now
        run_transfer(1'b0, make_addr(20'h00043, 8'h03, 2'd2), '0);
        run_transfer(1'b0, make_addr(20'h00041, 8'h03, 2'd3), '0);
        run_transfer(1'b0, make_addr(20'h00042, 8'h03, 2'd0), '0);   // evicted, misses
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 150; i++) begin
            r = next_rand();
            run_transfer(r[0], make_addr(20'h00100 + 20'(r[4:3]), 8'h04 + 8'(r[2:1]), r[6:5]),
                         next_rand());
        end
        end_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_l2_model.sv
/*
 * L2 memory model for the cache testbench.
 * Each word starts as its byte address XOR a fixed key, so the fill
 * depends on the whole address. Acks come 1 to 6 cycles after valid is
 * seen, drawn from an xorshift sequence. Outputs change on falling edges.
 */
module tb_l2_model #(
    parameter logic [31:0] seed = 32'd19333
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::l2_req_t l2_req,
    output cache_pkg::l2_rsp_t l2_rsp,
    output int                 line_reads,
    output int                 word_writes
);

    import cache_pkg::*;

    localparam logic [31:0] fill_key = 32'h5a5a_c3c3;

    logic [31:0] mem [logic [29:0]];   // word address keyed, sparse
    logic [31:0] rng_state;
    int          wait_left;
    logic        busy;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] word_at(input logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return {waddr, 2'b00} ^ fill_key;
    endfunction

    initial begin
        l2_rsp      = '0;
        line_reads  = 0;
        word_writes = 0;
        busy        = 1'b0;
        wait_left   = 0;
        rng_state   = seed;
    end

    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l2_rsp <= '0;
            busy   = 1'b0;
        end else if (l2_rsp.ack) begin
            l2_rsp.ack <= 1'b0;                // ack lasts one cycle
        end else if (l2_req.valid) begin
            if (!busy) begin
                busy      = 1'b1;
                rng_state = xorshift(rng_state);
                wait_left = rng_state % 6;
            end
            if (wait_left == 0) begin
                busy       = 1'b0;
                l2_rsp.ack <= 1'b1;
                if (l2_req.we) begin
                    mem[l2_req.addr[31:2]] = l2_req.wdata;
                    word_writes <= word_writes + 1;
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        l2_rsp.rdata[w] <= word_at({l2_req.addr[31:4], 2'(w)});
                    end
                    line_reads <= line_reads + 1;
                end
            end else begin
                wait_left--;
            end
        end
    end

endmodule
